/* design/axis_out_macros.svh */
`ifndef AXIS_OUT_MACROS_SVH
`define AXIS_OUT_MACROS_SVH

// Bus side word width
`define AXIS_OUT_BUS_W 32

// Stream side byte width
`define AXIS_OUT_TDATA_W 8

// Stream bytes per bus word
`define AXIS_OUT_LANES 4

// FIFO depth in bytes as log2, 16 bytes or 4 words
`define AXIS_OUT_DEPTH_LOG2 4

// Register address width and map
`define AXIS_OUT_ADDR_W 2
`define AXIS_OUT_ADDR_CTRL 2'd0
`define AXIS_OUT_ADDR_LAST 2'd1
`define AXIS_OUT_ADDR_IN 2'd2
`define AXIS_OUT_ADDR_STATUS 2'd3

`endif

/* design/axis_out_pkg.sv */
`include "axis_out_macros.svh"

package axis_out_pkg;

   // One word as written by the processor
   typedef logic [`AXIS_OUT_BUS_W-1:0] bus_word_t;

   // One byte on the stream
   typedef logic [`AXIS_OUT_TDATA_W-1:0] tdata_t;

   // One bit per byte lane of a bus word
   typedef logic [`AXIS_OUT_LANES-1:0] lane_mask_t;

   // Unread bytes in the FIFO, needs one bit above the depth
   typedef logic [`AXIS_OUT_DEPTH_LOG2:0] level_t;

   typedef logic [`AXIS_OUT_ADDR_W-1:0] reg_addr_t;

   // Register port write
   typedef struct packed {
      logic      wr;
      reg_addr_t addr;
      bus_word_t data;
   } bus_wr_t;

   // Control from the register block to the output stage
   typedef struct packed {
      logic       enable;
      logic       softreset;
      lane_mask_t last_mask;
      logic       last_wr;
   } out_ctrl_t;

   // Output stage frame tracking
   typedef enum logic [1:0] {
      IDLE,
      STREAM,
      LAST_PEND
   } framer_state_t;

endpackage

/* design/axis_out_regs.sv */
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_regs (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axis_out_pkg::bus_wr_t   bus_wr_i,
   input  logic                    rd_en_i,
   input  axis_out_pkg::reg_addr_t rd_addr_i,
   input  logic                    fifo_full_i,
   input  logic                    fifo_empty_i,
   input  axis_out_pkg::level_t    fifo_level_i,
   input  logic                    last_pend_i,
   output axis_out_pkg::bus_word_t rd_data_o,
   output logic                    fifo_wr_o,
   output axis_out_pkg::bus_word_t fifo_wdata_o,
   output axis_out_pkg::out_ctrl_t ctrl_o
);
   import axis_out_pkg::*;

   // Level field position in STATUS
   localparam int STATUS_LEVEL_LSB = 8;

   logic       ctrl_wr;
   logic       last_wr;
   logic       in_wr;
   logic       enable_q;
   logic       softreset_q;
   logic       last_wr_q;
   lane_mask_t last_mask_q;
   bus_word_t  status;
   bus_word_t  rd_mux;
   bus_word_t  rd_data_q;

   // Address decode of the write strobe
   assign ctrl_wr = bus_wr_i.wr && (bus_wr_i.addr == `AXIS_OUT_ADDR_CTRL);
   assign in_wr   = bus_wr_i.wr && (bus_wr_i.addr == `AXIS_OUT_ADDR_IN);

   // Mask may not change under a stored last word
   assign last_wr = bus_wr_i.wr && (bus_wr_i.addr == `AXIS_OUT_ADDR_LAST) && !last_pend_i;

   // IN writes dropped when no room or a last word still waits
   assign fifo_wr_o    = in_wr && !fifo_full_i && !last_pend_i;
   assign fifo_wdata_o = bus_wr_i.data;

   // ENABLE level and one cycle SOFTRESET pulse
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q    <= 1'b0;
         softreset_q <= 1'b0;
      end else begin
         softreset_q <= ctrl_wr && bus_wr_i.data[1];
         if (softreset_q) begin
            enable_q <= 1'b0;
         end else if (ctrl_wr) begin
            enable_q <= bus_wr_i.data[0];
         end
      end
   end

   // Lane mask for the next IN word
   // Consumed by that word, which then becomes the frame end
   always_ff @(posedge clk_i) begin
      if (rst_i || softreset_q) begin
         last_mask_q <= '0;
         last_wr_q   <= 1'b0;
      end else begin
         last_wr_q <= last_wr;
         if (last_wr) begin
            last_mask_q <= bus_wr_i.data[`AXIS_OUT_LANES-1:0];
         end else if (fifo_wr_o && (last_mask_q != '0)) begin
            last_mask_q <= '0;
         end
      end
   end

   assign ctrl_o.enable    = enable_q;
   assign ctrl_o.softreset = softreset_q;
   assign ctrl_o.last_mask = last_mask_q;
   assign ctrl_o.last_wr   = last_wr_q;

   // STATUS word, full also covers a waiting last word
   always_comb begin
      status    = '0;
      status[0] = fifo_full_i || last_pend_i;
      status[1] = fifo_empty_i;
      status[STATUS_LEVEL_LSB +: $bits(level_t)] = fifo_level_i;
   end

   // Read mux, IN is write only and SOFTRESET reads back zero
   always_comb begin
      rd_mux = '0;
      case (rd_addr_i)
         `AXIS_OUT_ADDR_CTRL:   rd_mux[0] = enable_q;
         `AXIS_OUT_ADDR_LAST:   rd_mux[`AXIS_OUT_LANES-1:0] = last_mask_q;
         `AXIS_OUT_ADDR_STATUS: rd_mux = status;
         default:               rd_mux = '0;
      endcase
   end

   // Read data appears the cycle after rd_en_i and holds
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_q <= rd_mux;
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

/* design/axis_out_fifo.sv */
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_fifo (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    flush_i,
   input  logic                    wr_i,
   input  axis_out_pkg::bus_word_t wdata_i,
   input  logic                    rd_i,
   output axis_out_pkg::tdata_t    rdata_o,
   output logic                    empty_o,
   output logic                    full_o,
   output axis_out_pkg::level_t    level_o
);
   import axis_out_pkg::*;

   // Byte depth and word organisation
   localparam int DEPTH   = 1 << `AXIS_OUT_DEPTH_LOG2;
   localparam int LANE_W  = $clog2(`AXIS_OUT_LANES);
   localparam int WORDS   = DEPTH / `AXIS_OUT_LANES;
   localparam int WADDR_W = `AXIS_OUT_DEPTH_LOG2 - LANE_W;

   // Full as soon as a whole word no longer fits
   localparam level_t FULL_LEVEL = level_t'(DEPTH - `AXIS_OUT_LANES);

   // Word storage
   bus_word_t mem [WORDS];

   // Write pointer in words
   logic [WADDR_W-1:0] wptr_q;

   // Read pointer in bytes, low bits select the lane
   logic [`AXIS_OUT_DEPTH_LOG2-1:0] rptr_q;

   level_t level_q;
   level_t level_d;

   logic               do_wr;
   logic               do_rd;
   logic [WADDR_W-1:0] rd_word_addr;
   logic [LANE_W-1:0]  rd_lane;
   bus_word_t          rd_word;

   assign empty_o = (level_q == '0);
   assign full_o  = (level_q > FULL_LEVEL);
   assign level_o = level_q;

   // Accesses beyond the limits are ignored
   assign do_wr = wr_i && !full_o;
   assign do_rd = rd_i && !empty_o;

   // Word write, lane 0 in the low byte
   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wptr_q] <= wdata_i;
      end
   end

   // Head byte presented without a read strobe
   assign rd_word_addr = rptr_q[`AXIS_OUT_DEPTH_LOG2-1:LANE_W];
   assign rd_lane      = rptr_q[LANE_W-1:0];
   assign rd_word      = mem[rd_word_addr];
   assign rdata_o      = rd_word[rd_lane*`AXIS_OUT_TDATA_W +: `AXIS_OUT_TDATA_W];

   // Word in, byte out
   always_comb begin
      level_d = level_q;
      if (do_wr) begin
         level_d = level_d + level_t'(`AXIS_OUT_LANES);
      end
      if (do_rd) begin
         level_d = level_d - level_t'(1);
      end
   end

   // Pointers wrap by width
   always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else begin
         level_q <= level_d;
         if (do_wr) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (do_rd) begin
            rptr_q <= rptr_q + 1'b1;
         end
      end
   end

endmodule

/* design/axis_out_framer.sv */
`timescale 1ns/1ps
`include "axis_out_macros.svh"

module axis_out_framer (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axis_out_pkg::out_ctrl_t ctrl_i,
   input  logic                    fifo_wr_i,
   input  axis_out_pkg::tdata_t    fifo_rdata_i,
   input  logic                    fifo_empty_i,
   input  axis_out_pkg::level_t    fifo_level_i,
   input  logic                    tready_i,
   output logic                    fifo_rd_o,
   output logic                    last_pend_o,
   output axis_out_pkg::tdata_t    tdata_o,
   output logic                    tvalid_o,
   output logic                    tlast_o
);
   import axis_out_pkg::*;

   localparam int LANE_W = $clog2(`AXIS_OUT_LANES);
   localparam logic [LANE_W-1:0] TOP_LANE = LANE_W'(`AXIS_OUT_LANES - 1);

   framer_state_t     state_q;
   framer_state_t     state_d;
   lane_mask_t        mask_q;
   logic [LANE_W-1:0] skip_q;
   tdata_t            tdata_q;
   logic              tvalid_q;
   logic              tlast_q;

   level_t            lane_full;
   logic [LANE_W-1:0] lane;
   logic [LANE_W-1:0] lane_nxt;
   logic              on_last;
   logic              lane_en;
   logic              lane_is_top;
   logic              slot_free;
   logic              load;
   logic              load_last;
   logic              skip;

   // Last word at the FIFO head, no IN write lands behind it
   assign on_last   = (state_q == LAST_PEND) && (fifo_level_i <= level_t'(`AXIS_OUT_LANES));
   assign lane_full = level_t'(`AXIS_OUT_LANES) - fifo_level_i;
   assign lane      = lane_full[LANE_W-1:0];
   assign lane_nxt  = lane + 1'b1;
   assign lane_en   = mask_q[lane];

   // Contiguous mask, so the next lane being off ends the frame
   assign lane_is_top = (lane == TOP_LANE) || !mask_q[lane_nxt];

   // Output register empty or being emptied this cycle
   assign slot_free = !tvalid_q || tready_i;

   // New byte only when enabled and no dropped lanes ahead of it
   assign load = ctrl_i.enable && slot_free && !fifo_empty_i && (skip_q == '0) &&
                 (!on_last || lane_en);
   assign load_last = on_last && lane_is_top;

   // Dropped lanes leave at one per cycle
   assign skip = (skip_q != '0);

   assign fifo_rd_o = load || skip;

   // Frame tracking
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE, STREAM: begin
            if (fifo_wr_i) begin
               state_d = (ctrl_i.last_mask != '0) ? LAST_PEND : STREAM;
            end
         end
         LAST_PEND: begin
            if (tvalid_q && tready_i && tlast_q) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.softreset) begin
         state_q <= IDLE;
         mask_q  <= '0;
         skip_q  <= '0;
      end else begin
         state_q <= state_d;
         // Own copy, the register block clears its mask once consumed
         if (ctrl_i.last_wr) begin
            mask_q <= ctrl_i.last_mask;
         end
         // Lanes left behind the tlast byte are all disabled
         if (load && load_last) begin
            skip_q <= fifo_level_i[LANE_W-1:0] - 1'b1;
         end else if (skip) begin
            skip_q <= skip_q - 1'b1;
         end
      end
   end

   // Output register, held while tready_i is low
   always_ff @(posedge clk_i) begin
      if (rst_i || ctrl_i.softreset) begin
         tvalid_q <= 1'b0;
         tlast_q  <= 1'b0;
      end else if (load) begin
         tvalid_q <= 1'b1;
         tlast_q  <= load_last;
      end else if (tready_i) begin
         tvalid_q <= 1'b0;
         tlast_q  <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         tdata_q <= fifo_rdata_i;
      end
   end

   assign last_pend_o = (state_q == LAST_PEND);
   assign tdata_o     = tdata_q;
   assign tvalid_o    = tvalid_q;
   assign tlast_o     = tlast_q;

endmodule

/* design/axis_out_top.sv */
`timescale 1ns/1ps

module axis_out_top (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axis_out_pkg::bus_wr_t   bus_wr_i,
   input  logic                    rd_en_i,
   input  axis_out_pkg::reg_addr_t rd_addr_i,
   input  logic                    tready_i,
   output axis_out_pkg::bus_word_t rd_data_o,
   output axis_out_pkg::tdata_t    tdata_o,
   output logic                    tvalid_o,
   output logic                    tlast_o
);
   import axis_out_pkg::*;

   // Register block to FIFO and output stage
   logic      fifo_wr;
   bus_word_t fifo_wdata;
   out_ctrl_t ctrl;

   // FIFO state and head byte
   tdata_t    fifo_rdata;
   logic      fifo_empty;
   logic      fifo_full;
   level_t    fifo_level;

   // Output stage back to FIFO and STATUS
   logic      fifo_rd;
   logic      last_pend;

   axis_out_regs axis_out_regs_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .bus_wr_i    (bus_wr_i),
      .rd_en_i     (rd_en_i),
      .rd_addr_i   (rd_addr_i),
      .fifo_full_i (fifo_full),
      .fifo_empty_i(fifo_empty),
      .fifo_level_i(fifo_level),
      .last_pend_i (last_pend),
      .rd_data_o   (rd_data_o),
      .fifo_wr_o   (fifo_wr),
      .fifo_wdata_o(fifo_wdata),
      .ctrl_o      (ctrl)
   );

   // SOFTRESET flushes the stored bytes
   axis_out_fifo axis_out_fifo_i (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .flush_i(ctrl.softreset),
      .wr_i   (fifo_wr),
      .wdata_i(fifo_wdata),
      .rd_i   (fifo_rd),
      .rdata_o(fifo_rdata),
      .empty_o(fifo_empty),
      .full_o (fifo_full),
      .level_o(fifo_level)
   );

   axis_out_framer axis_out_framer_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .ctrl_i      (ctrl),
      .fifo_wr_i   (fifo_wr),
      .fifo_rdata_i(fifo_rdata),
      .fifo_empty_i(fifo_empty),
      .fifo_level_i(fifo_level),
      .tready_i    (tready_i),
      .fifo_rd_o   (fifo_rd),
      .last_pend_o (last_pend),
      .tdata_o     (tdata_o),
      .tvalid_o    (tvalid_o),
      .tlast_o     (tlast_o)
   );

endmodule

/* tb/axis_out_chk.sv */
`timescale 1ns/1ps

module axis_out_chk (
   input logic                 clk_i,
   input logic                 rst_i,
   input logic                 tready_i,
   input logic                 tvalid_o,
   input logic                 tlast_o,
   input axis_out_pkg::tdata_t tdata_o
);

   // Presented byte held until the sink takes it
   stall_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
      (tvalid_o && !tready_i) |=> ($stable(tdata_o) && $stable(tlast_o)))
      else $error("tdata_o or tlast_o changed while stalled");

   // A frame end only on a valid byte
   last_valid_a: assert property (@(posedge clk_i) disable iff (rst_i)
      tlast_o |-> tvalid_o)
      else $error("tlast_o high without tvalid_o");

   // Stream idle right after reset
   reset_idle_a: assert property (@(posedge clk_i)
      rst_i |=> !tvalid_o)
      else $error("tvalid_o high in the cycle after reset");

endmodule

bind axis_out_top axis_out_chk axis_out_chk_i (.*);

/* tb/axis_out_tb.sv */
`timescale 1ns/1ps

module axis_out_tb;
   import axis_out_pkg::*;

   localparam string GOLDEN = "tb/axis_out_golden.txt";

   logic      clk_i = 1'b0;
   logic      rst_i;
   bus_wr_t   bus_wr_i;
   logic      rd_en_i;
   reg_addr_t rd_addr_i;
   logic      tready_i;
   bus_word_t rd_data_o;
   tdata_t    tdata_o;
   logic      tvalid_o;
   logic      tlast_o;

   // Expected stream, last flag above the byte
   logic [8:0]  exp_q[$];
   // Bytes taken from the stream, same layout
   logic [8:0]  got_q[$];
   logic [8:0]  mon_exp;
   logic [8:0]  mon_got;
   logic [31:0] rng_state = 32'h9260_9ec8;
   int          ready_mode = 0;
   int          cycles = 0;
   int          cycle_limit = 0;
   int          test_errs = 0;
   int          tests_pass = 0;
   int          tests_fail = 0;
   bit          test_open = 1'b0;
   string       test_name = "none";

   axis_out_top axis_out_top_i (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .bus_wr_i (bus_wr_i),
      .rd_en_i  (rd_en_i),
      .rd_addr_i(rd_addr_i),
      .tready_i (tready_i),
      .rd_data_o(rd_data_o),
      .tdata_o  (tdata_o),
      .tvalid_o (tvalid_o),
      .tlast_o  (tlast_o)
   );

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act) begin
         $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
         test_errs++;
      end
   endtask

   // Sink readiness, changed just after the edge
   always @(posedge clk_i) begin
      #2;
      if (ready_mode == 1) begin
         tready_i = 1'b1;
      end else begin
         rng_state = xorshift32(rng_state);
         tready_i  = rng_state[0];
      end
   end

   // Transfer seen at the falling edge, taken at the next rising one
   always @(negedge clk_i) begin
      if (!rst_i && tvalid_o && tready_i) begin
         got_q.push_back({tlast_o, tdata_o});
      end
      // Bytes may leave before their S lines are read
      while (exp_q.size() != 0 && got_q.size() != 0) begin
         mon_exp = exp_q.pop_front();
         mon_got = got_q.pop_front();
         check_value("tdata", {24'h0, mon_exp[7:0]}, {24'h0, mon_got[7:0]});
         check_value("tlast", {31'h0, mon_exp[8]}, {31'h0, mon_got[8]});
      end
   end

   // Watchdog
   always @(posedge clk_i) begin
      cycles++;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         $display("Run timed out after %0d cycles, expected bytes never arrived", cycles);
         $display("Something failed");
         $finish;
      end
   end

   task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      #2;
      bus_wr_i.wr   = 1'b1;
      bus_wr_i.addr = addr;
      bus_wr_i.data = data;
      @(posedge clk_i);
      #2;
      bus_wr_i.wr = 1'b0;
   endtask

   // Stream must settle first, skip cycles of dropped lanes included
   task automatic drain();
      while (exp_q.size() != 0) begin
         @(posedge clk_i);
      end
      repeat (4) @(posedge clk_i);
      if (got_q.size() != 0) begin
         $display("Test %s saw %0d bytes on the stream that were never expected",
                  test_name, got_q.size());
         test_errs++;
         got_q.delete();
      end
   endtask

   task automatic reg_read(input logic [1:0] addr, input logic [31:0] exp);
      drain();
      #2;
      rd_en_i   = 1'b1;
      rd_addr_i = addr;
      @(posedge clk_i);
      #2;
      rd_en_i = 1'b0;
      check_value($sformatf("read of register %0d", addr), exp, rd_data_o);
   endtask

   task automatic queue_bytes(input logic [31:0] word, input logic [31:0] count,
                              input logic last);
      int i;
      for (i = 0; i < int'(count); i++) begin
         exp_q.push_back({last && (i == int'(count) - 1), word[i*8 +: 8]});
      end
   endtask

   task automatic finish_test();
      if (test_open) begin
         drain();
         if (test_errs == 0) begin
            $display("Test %s passed", test_name);
            tests_pass++;
         end else begin
            $display("Test %s failed with %0d errors", test_name, test_errs);
            tests_fail++;
         end
         test_errs = 0;
      end
   endtask

   // One golden line at a time, in file order
   task automatic run_commands();
      int          fd;
      string       line;
      logic [7:0]  cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      fd = $fopen(GOLDEN, "r");
      while (!$feof(fd)) begin
         if ($fgets(line, fd) == 0) begin
            continue;
         end
         if (line.len() < 2 || line[0] == "#") begin
            continue;
         end
         cmd = line[0];
         case (cmd)
            "T": begin
               finish_test();
               test_name = line.substr(2, line.len() - 2);
               test_open = 1'b1;
            end
            "W": begin
               void'($sscanf(line, "W %h %h", a, b));
               bus_write(a[1:0], b);
            end
            "R": begin
               void'($sscanf(line, "R %h %h", a, b));
               reg_read(a[1:0], b);
            end
            "S": begin
               void'($sscanf(line, "S %h %h %h", a, b, c));
               queue_bytes(a, b, c[0]);
            end
            "P": begin
               void'($sscanf(line, "P %h", a));
               ready_mode = int'(a);
            end
            default: begin
               $display("Unknown command in golden line: %s", line);
               test_errs++;
            end
         endcase
      end
      $fclose(fd);
   endtask

   initial begin
      int    fd;
      int    n_lines;
      string line;
      rst_i     = 1'b1;
      bus_wr_i  = '0;
      rd_en_i   = 1'b0;
      rd_addr_i = '0;
      tready_i  = 1'b0;
      n_lines   = 0;

      // Limit scales with the script length
      fd = $fopen(GOLDEN, "r");
      if (fd == 0) begin
         $display("Cannot open %s", GOLDEN);
         $display("Something failed");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
               n_lines++;
            end
         end
         $fclose(fd);
         cycle_limit = n_lines * 64 + 200;

         repeat (3) @(posedge clk_i);
         #2;
         rst_i = 1'b0;

         run_commands();
         finish_test();

         $display("Tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
         if (tests_fail == 0 && test_errs == 0) begin
            $display("Everything OK");
         end else begin
            $display("Something failed");
         end
         $finish;
      end
   end

endmodule

/* build.f */
+incdir+design
design/axis_out_pkg.sv
design/axis_out_regs.sv
design/axis_out_fifo.sv
design/axis_out_framer.sv
design/axis_out_top.sv
tb/axis_out_chk.sv
tb/axis_out_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the axis_out testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module axis_out_tb \
   -Mdir obj_dir -o axis_out_sim > sim.log 2>&1 \
   && ./obj_dir/axis_out_sim >> sim.log 2>&1 \
   || echo "Something failed" >> sim.log

cat sim.log

if grep -q "Something failed" sim.log; then
   echo "Simulation FAILED, see sim.log"
   exit 1
else
   echo "Simulation passed"
   exit 0
fi

/* tb/axis_out_golden.txt */
# W addr data | R addr expected | S word bytes last (lane 0 first) | P ready mode | T test name
# P 1 holds tready high, P 0 gives random tready
T ordering
P 1
W 0 00000001
W 2 44332211
W 2 88776655
W 1 0000000f
W 2 ccbbaa99
S 44332211 4 0
S 88776655 4 0
S ccbbaa99 4 1
R 3 00000002
T partial_last
W 1 00000001
W 2 a3a2a1a0
S a3a2a1a0 1 1
R 3 00000002
W 1 00000003
W 2 b3b2b1b0
S b3b2b1b0 2 1
R 3 00000002
W 1 00000007
W 2 c3c2c1c0
S c3c2c1c0 3 1
R 3 00000002
W 1 0000000f
W 2 d3d2d1d0
S d3d2d1d0 4 1
R 3 00000002
T enable_gating
W 0 00000000
W 2 deadbeef
W 2 cafef00d
R 3 00000800
W 0 00000001
S deadbeef 4 0
S cafef00d 4 0
R 3 00000002
T back_pressure
P 0
W 2 01020304
W 2 05060708
W 1 00000003
W 2 0a0b0c0d
S 01020304 4 0
S 05060708 4 0
S 0a0b0c0d 2 1
R 3 00000002
T full_refusal
W 0 00000000
W 2 13121110
W 2 17161514
W 2 1b1a1918
W 2 1f1e1d1c
W 2 99999999
R 3 00001001
W 0 00000001
S 13121110 4 0
S 17161514 4 0
S 1b1a1918 4 0
S 1f1e1d1c 4 0
R 3 00000002
W 0 00000000
W 1 00000003
W 2 23222120
R 3 00000401
W 0 00000001
S 23222120 2 1
R 3 00000002
T softreset
W 0 00000000
W 2 55555555
W 2 66666666
W 0 00000002
R 3 00000002
R 0 00000000
W 0 00000001
W 1 00000001
W 2 33323130
S 33323130 1 1
R 3 00000002
